//--- Makefile
TOOL     = verilator
FLAGS    = --binary --timing --assert --timescale 1ns/1ps
LINT     = --lint-only --timing --timescale 1ns/1ps
TOP      = tb_top
FILELIST = project.f
OBJ      = obj_dir
PASS     = All checks passed

.PHONY: lint sim clean

lint:
	$(TOOL) $(LINT) --top-module $(TOP) -f $(FILELIST)

sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ)
	out=$$(./$(OBJ)/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS)"

clean:
	rm -rf $(OBJ)

//--- project.f
source/core_pkg.sv
source/reg_file.sv
source/busy_table.sv
source/inst_decode.sv
source/alu_exec.sv
source/decode_exec_top.sv
verif/tb_clk_gen.sv
verif/decode_exec_chk.sv
verif/tb_top.sv

//--- source/alu_exec.sv
`timescale 1ns/1ps
`default_nettype none

module alu_exec
  import core_pkg::*;
(
  input  wire logic     clk,
  input  wire logic     rst,
  input  wire logic     ex_valid_i,
  output logic          ex_ready_o,
  input  wire alu_op_t  alu_op_i,
  input  wire word_t    op_a_i,
  input  wire word_t    op_b_i,
  input  wire reg_idx_t rd_i,
  input  wire logic     wr_en_i,
  input  wire logic     is_branch_i,
  input  wire word_t    jump_target_i,
  input  wire word_t    pc_i,
  output logic          wb_valid_o,
  input  wire logic     wb_ready_i,
  output reg_idx_t      wb_rd_o,
  output word_t         wb_data_o,
  output word_t         wb_pc_o,
  output logic          wb_taken_o,
  output word_t         wb_target_o,
  output logic          rf_we_o,
  output logic          fwd_valid_o,
  output reg_idx_t      fwd_rd_o,
  output word_t         fwd_data_o
);

  logic     s1_valid;
  alu_op_t  s1_alu_op;
  word_t    s1_a, s1_b, s1_target, s1_pc;
  reg_idx_t s1_rd;
  logic     s1_wr_en, s1_is_branch;
  word_t    alu_res;
  logic     cond;
  logic     wb_free;
  logic     wb_wr_en;

  assign wb_free    = !wb_valid_o || wb_ready_i;
  assign ex_ready_o = !s1_valid || wb_free;

  always_ff @(posedge clk) begin
    if (rst) begin
      s1_valid <= 1'b0;
    end else if (ex_ready_o) begin
      s1_valid <= ex_valid_i;
    end
  end

  always_ff @(posedge clk) begin
    if (ex_valid_i && ex_ready_o) begin
      s1_alu_op    <= alu_op_i;
      s1_a         <= op_a_i;
      s1_b         <= op_b_i;
      s1_rd        <= rd_i;
      s1_wr_en     <= wr_en_i;
      s1_is_branch <= is_branch_i;
      s1_target    <= jump_target_i;
      s1_pc        <= pc_i;
    end
  end

  always_comb begin
    case (s1_alu_op)
      ALU_ADD:  alu_res = s1_a + s1_b;
      ALU_SUB:  alu_res = s1_a - s1_b;
      ALU_SLL:  alu_res = s1_a << s1_b[4:0];
      ALU_SLT:  alu_res = {31'b0, $signed(s1_a) < $signed(s1_b)};
      ALU_SLTU: alu_res = {31'b0, s1_a < s1_b};
      ALU_XOR:  alu_res = s1_a ^ s1_b;
      ALU_SRL:  alu_res = s1_a >> s1_b[4:0];
      ALU_SRA:  alu_res = $signed(s1_a) >>> s1_b[4:0];
      ALU_OR:   alu_res = s1_a | s1_b;
      ALU_AND:  alu_res = s1_a & s1_b;
      default:  alu_res = '0;
    endcase
  end

  // Branch condition from funct3.
  always_comb begin
    case (s1_alu_op[2:0])
      3'b000:  cond = (s1_a == s1_b);
      3'b001:  cond = (s1_a != s1_b);
      3'b100:  cond = ($signed(s1_a) < $signed(s1_b));
      3'b101:  cond = ($signed(s1_a) >= $signed(s1_b));
      3'b110:  cond = (s1_a < s1_b);
      3'b111:  cond = (s1_a >= s1_b);
      default: cond = 1'b0;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      wb_valid_o <= 1'b0;
    end else if (wb_free) begin
      wb_valid_o <= s1_valid;
    end
  end

  // A control op with a write is a jump, always taken.
  always_ff @(posedge clk) begin
    if (s1_valid && wb_free) begin
      wb_rd_o     <= s1_rd;
      wb_wr_en    <= s1_wr_en;
      wb_data_o   <= (s1_is_branch && !s1_wr_en) ? '0 : alu_res;
      wb_pc_o     <= s1_pc;
      wb_taken_o  <= s1_is_branch && (s1_wr_en || cond);
      wb_target_o <= s1_target;
    end
  end

  assign rf_we_o = wb_valid_o && wb_ready_i && wb_wr_en;

  // No forwarding while a newer write to the same register sits in the ALU stage.
  assign fwd_valid_o = wb_valid_o && wb_wr_en && (wb_rd_o != '0) &&
                       !(s1_valid && s1_wr_en && (s1_rd == wb_rd_o));
  assign fwd_rd_o    = wb_rd_o;
  assign fwd_data_o  = wb_data_o;

endmodule

`default_nettype wire

//--- source/busy_table.sv
`timescale 1ns/1ps
`default_nettype none

module busy_table
  import core_pkg::*;
(
  input  wire logic                clk,
  input  wire logic                rst,
  input  wire logic                set_en_i,
  input  wire reg_idx_t            set_idx_i,
  input  wire logic                clr_en_i,
  input  wire reg_idx_t            clr_idx_i,
  output logic [NUM_REGS-1:0]      busy_o
);

  logic [NUM_REGS-1:0] busy_q;

  // A set in the same cycle as a clear of that index comes from a newer
  // producer, so it is applied last and wins.
  always_ff @(posedge clk) begin
    if (rst) begin
      busy_q <= '0;
    end else begin
      if (clr_en_i) begin
        busy_q[clr_idx_i] <= 1'b0;
      end
      if (set_en_i && set_idx_i != '0) begin
        busy_q[set_idx_i] <= 1'b1;  // x0 never tracked.
      end
    end
  end

  assign busy_o = busy_q;

endmodule

`default_nettype wire

//--- source/core_pkg.sv
`default_nettype none

package core_pkg;

  typedef logic [31:0] word_t;     // Operands, results and PCs.
  typedef logic [31:0] inst_t;
  typedef logic [3:0]  reg_idx_t;  // RV32E has 16 registers.
  typedef logic [3:0]  alu_op_t;   // {funct7[5], funct3}.
  typedef logic [6:0]  opcode_t;

  localparam int NUM_REGS = 16;

  // Major opcodes.
  localparam opcode_t OP_LUI    = 7'b0110111;
  localparam opcode_t OP_AUIPC  = 7'b0010111;
  localparam opcode_t OP_JAL    = 7'b1101111;
  localparam opcode_t OP_JALR   = 7'b1100111;
  localparam opcode_t OP_BRANCH = 7'b1100011;
  localparam opcode_t OP_IMM    = 7'b0010011;
  localparam opcode_t OP_REG    = 7'b0110011;

  // ALU operations, funct7 bit 5 in front of funct3.
  localparam alu_op_t ALU_ADD  = 4'b0000;
  localparam alu_op_t ALU_SUB  = 4'b1000;
  localparam alu_op_t ALU_SLL  = 4'b0001;
  localparam alu_op_t ALU_SLT  = 4'b0010;
  localparam alu_op_t ALU_SLTU = 4'b0011;
  localparam alu_op_t ALU_XOR  = 4'b0100;
  localparam alu_op_t ALU_SRL  = 4'b0101;
  localparam alu_op_t ALU_SRA  = 4'b1101;
  localparam alu_op_t ALU_OR   = 4'b0110;
  localparam alu_op_t ALU_AND  = 4'b0111;

endpackage

`default_nettype wire

//--- source/decode_exec_top.sv
`timescale 1ns/1ps
`default_nettype none

module decode_exec_top
  import core_pkg::*;
(
  input  wire logic  clk,
  input  wire logic  rst,
  input  wire logic  issue_valid_i,
  input  wire inst_t inst_i,
  input  wire word_t pc_i,
  output logic       issue_ready_o,
  output logic       wb_valid_o,
  input  wire logic  wb_ready_i,
  output reg_idx_t   wb_rd_o,
  output word_t      wb_data_o,
  output word_t      wb_pc_o,
  output logic       wb_taken_o,
  output word_t      wb_target_o,
  output logic       illegal_o
);

  reg_idx_t            rs1, rs2, rd, set_idx, fwd_rd;
  word_t               rdata1, rdata2, fwd_data, op_a, op_b, jump_target, pc;
  logic [NUM_REGS-1:0] busy;
  logic                set_en, fwd_valid, rf_we;
  logic                ex_valid, ex_ready, wr_en, is_branch;
  alu_op_t             alu_op;

  reg_file i_reg_file (
    .clk, .rst,
    .rs1_i(rs1), .rs2_i(rs2), .rdata1_o(rdata1), .rdata2_o(rdata2),
    .we_i(rf_we), .waddr_i(wb_rd_o), .wdata_i(wb_data_o)
  );

  busy_table i_busy_table (
    .clk, .rst,
    .set_en_i(set_en), .set_idx_i(set_idx),
    .clr_en_i(rf_we), .clr_idx_i(wb_rd_o),  // Cleared on retire.
    .busy_o(busy)
  );

  inst_decode i_decode (
    .clk, .rst,
    .issue_valid_i, .inst_i, .pc_i, .issue_ready_o,
    .rs1_o(rs1), .rs2_o(rs2), .rdata1_i(rdata1), .rdata2_i(rdata2), .busy_i(busy),
    .fwd_valid_i(fwd_valid), .fwd_rd_i(fwd_rd), .fwd_data_i(fwd_data),
    .set_en_o(set_en), .set_idx_o(set_idx),
    .ex_valid_o(ex_valid), .ex_ready_i(ex_ready),
    .alu_op_o(alu_op), .op_a_o(op_a), .op_b_o(op_b), .rd_o(rd), .wr_en_o(wr_en),
    .is_branch_o(is_branch), .jump_target_o(jump_target), .pc_o(pc),
    .illegal_o
  );

  alu_exec i_exec (
    .clk, .rst,
    .ex_valid_i(ex_valid), .ex_ready_o(ex_ready),
    .alu_op_i(alu_op), .op_a_i(op_a), .op_b_i(op_b), .rd_i(rd), .wr_en_i(wr_en),
    .is_branch_i(is_branch), .jump_target_i(jump_target), .pc_i(pc),
    .wb_valid_o, .wb_ready_i, .wb_rd_o, .wb_data_o, .wb_pc_o, .wb_taken_o, .wb_target_o,
    .rf_we_o(rf_we), .fwd_valid_o(fwd_valid), .fwd_rd_o(fwd_rd), .fwd_data_o(fwd_data)
  );

endmodule

`default_nettype wire

//--- source/inst_decode.sv
`timescale 1ns/1ps
`default_nettype none

module inst_decode
  import core_pkg::*;
(
  input  wire logic                clk,
  input  wire logic                rst,
  input  wire logic                issue_valid_i,
  input  wire inst_t               inst_i,
  input  wire word_t               pc_i,
  output logic                     issue_ready_o,
  output reg_idx_t                 rs1_o,
  output reg_idx_t                 rs2_o,
  input  wire word_t               rdata1_i,
  input  wire word_t               rdata2_i,
  input  wire logic [NUM_REGS-1:0] busy_i,
  input  wire logic                fwd_valid_i,
  input  wire reg_idx_t            fwd_rd_i,
  input  wire word_t               fwd_data_i,
  output logic                     set_en_o,
  output reg_idx_t                 set_idx_o,
  output logic                     ex_valid_o,
  input  wire logic                ex_ready_i,
  output alu_op_t                  alu_op_o,
  output word_t                    op_a_o,
  output word_t                    op_b_o,
  output reg_idx_t                 rd_o,
  output logic                     wr_en_o,
  output logic                     is_branch_o,
  output word_t                    jump_target_o,
  output word_t                    pc_o,
  output logic                     illegal_o
);

  logic     valid_q;
  inst_t    inst_q;
  word_t    pc_q;
  opcode_t  opcode;
  logic [2:0] funct3;
  logic     funct7_b5;
  reg_idx_t rs1, rs2;
  word_t    imm_i, imm_b, imm_u, imm_j;
  logic     fwd1, fwd2;
  word_t    src1, src2;
  logic     use_rs1, use_rs2;
  logic     illegal;
  logic     hazard;
  logic     ex_fire;

  assign opcode    = inst_q[6:0];
  assign funct3    = inst_q[14:12];
  assign funct7_b5 = inst_q[30];
  assign rs1       = inst_q[18:15];  // Upper index bit is unused in RV32E.
  assign rs2       = inst_q[23:20];

  assign imm_i = {{20{inst_q[31]}}, inst_q[31:20]};
  assign imm_b = {{19{inst_q[31]}}, inst_q[31], inst_q[7], inst_q[30:25], inst_q[11:8], 1'b0};
  assign imm_u = {inst_q[31:12], 12'b0};
  assign imm_j = {{11{inst_q[31]}}, inst_q[31], inst_q[19:12], inst_q[20], inst_q[30:21], 1'b0};

  // Writeback result overrides the register file.
  assign fwd1 = fwd_valid_i && (fwd_rd_i == rs1);
  assign fwd2 = fwd_valid_i && (fwd_rd_i == rs2);
  assign src1 = fwd1 ? fwd_data_i : rdata1_i;
  assign src2 = fwd2 ? fwd_data_i : rdata2_i;

  always_comb begin
    use_rs1       = 1'b0;
    use_rs2       = 1'b0;
    illegal       = 1'b0;
    alu_op_o      = ALU_ADD;
    op_a_o        = '0;
    op_b_o        = '0;
    wr_en_o       = 1'b1;
    is_branch_o   = 1'b0;
    jump_target_o = '0;
    case (opcode)
      OP_LUI: begin
        op_b_o = imm_u;
      end
      OP_AUIPC: begin
        op_a_o = pc_q;
        op_b_o = imm_u;
      end
      OP_JAL: begin
        op_a_o        = pc_q;
        op_b_o        = 32'd4;  // Link value.
        is_branch_o   = 1'b1;
        jump_target_o = pc_q + imm_j;
      end
      OP_JALR: begin
        use_rs1       = 1'b1;
        op_a_o        = pc_q;
        op_b_o        = 32'd4;
        is_branch_o   = 1'b1;
        jump_target_o = (src1 + imm_i) & ~32'd1;
      end
      OP_BRANCH: begin
        use_rs1       = 1'b1;
        use_rs2       = 1'b1;
        alu_op_o      = {1'b0, funct3};  // Condition code for execute.
        op_a_o        = src1;
        op_b_o        = src2;
        wr_en_o       = 1'b0;
        is_branch_o   = 1'b1;
        jump_target_o = pc_q + imm_b;
      end
      OP_IMM: begin
        use_rs1  = 1'b1;
        alu_op_o = {(funct3 == 3'b101) && funct7_b5, funct3};  // Only SRAI uses bit 30.
        op_a_o   = src1;
        op_b_o   = imm_i;
      end
      OP_REG: begin
        use_rs1  = 1'b1;
        use_rs2  = 1'b1;
        alu_op_o = {funct7_b5, funct3};
        op_a_o   = src1;
        op_b_o   = src2;
      end
      default: begin
        illegal = 1'b1;
        wr_en_o = 1'b0;
      end
    endcase
  end

  assign hazard = valid_q && ((use_rs1 && busy_i[rs1] && !fwd1) ||
                              (use_rs2 && busy_i[rs2] && !fwd2));

  assign ex_valid_o    = valid_q && !hazard && !illegal;
  assign ex_fire       = ex_valid_o && ex_ready_i;
  assign issue_ready_o = !valid_q || ex_fire || illegal;  // Illegal ones are dropped.
  assign illegal_o     = valid_q && illegal;

  assign set_en_o  = ex_fire && wr_en_o && (rd_o != '0);
  assign set_idx_o = rd_o;

  assign rs1_o = rs1;
  assign rs2_o = rs2;
  assign rd_o  = inst_q[10:7];
  assign pc_o  = pc_q;

  always_ff @(posedge clk) begin
    if (rst) begin
      valid_q <= 1'b0;
    end else if (issue_ready_o) begin
      valid_q <= issue_valid_i;
    end
  end

  always_ff @(posedge clk) begin
    if (issue_valid_i && issue_ready_o) begin
      inst_q <= inst_i;
      pc_q   <= pc_i;
    end
  end

endmodule

`default_nettype wire

//--- source/reg_file.sv
`timescale 1ns/1ps
`default_nettype none

module reg_file
  import core_pkg::*;
(
  input  wire logic     clk,
  input  wire logic     rst,
  input  wire reg_idx_t rs1_i,
  input  wire reg_idx_t rs2_i,
  output word_t         rdata1_o,
  output word_t         rdata2_o,
  input  wire logic     we_i,
  input  wire reg_idx_t waddr_i,
  input  wire word_t    wdata_i
);

  word_t regs [NUM_REGS];

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (we_i && waddr_i != '0) begin
      regs[waddr_i] <= wdata_i;
    end
  end

  assign rdata1_o = (rs1_i == '0) ? '0 : regs[rs1_i];  // x0 reads as zero.
  assign rdata2_o = (rs2_i == '0) ? '0 : regs[rs2_i];

endmodule

`default_nettype wire

//--- verif/decode_exec_chk.sv
`timescale 1ns/1ps
`default_nettype none

module decode_exec_chk
  import core_pkg::*;
#(
  parameter int PW = 1
) (
  input wire logic          clk,
  input wire logic          rst,
  input wire logic          valid_i,
  input wire logic          ready_i,
  input wire logic [PW-1:0] payload_i,
  input wire logic          tgt_en_i,
  input wire reg_idx_t      tgt_idx_i
);

  a_hold_valid: assert property (@(posedge clk) disable iff (rst)
    valid_i && !ready_i |=> valid_i)
    else $error("valid fell without a transfer");

  a_stable_payload: assert property (@(posedge clk) disable iff (rst)
    valid_i && !ready_i |=> $stable(payload_i))
    else $error("payload changed while stalled");

  a_no_x0_target: assert property (@(posedge clk) disable iff (rst)
    tgt_en_i |-> tgt_idx_i != '0)
    else $error("register x0 targeted by a busy set or a forward");

endmodule

// Decode to execute handshake.
bind inst_decode decode_exec_chk #(.PW(138)) i_dec_chk (
  .clk, .rst, .valid_i(ex_valid_o), .ready_i(ex_ready_i),
  .payload_i({alu_op_o, op_a_o, op_b_o, rd_o, wr_en_o, is_branch_o, jump_target_o, pc_o}),
  .tgt_en_i(set_en_o), .tgt_idx_i(set_idx_o)
);

// Writeback handshake and forwarding port.
bind alu_exec decode_exec_chk #(.PW(101)) i_wb_chk (
  .clk, .rst, .valid_i(wb_valid_o), .ready_i(wb_ready_i),
  .payload_i({wb_rd_o, wb_data_o, wb_pc_o, wb_taken_o, wb_target_o}),
  .tgt_en_i(fwd_valid_o), .tgt_idx_i(fwd_rd_o)
);

`default_nettype wire

//--- verif/tb_clk_gen.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clk_gen (
  output logic clk_o,
  output logic rst_o
);

  initial begin
    clk_o = 1'b0;
    forever #50 clk_o = ~clk_o;  // 100 ns period.
  end

  initial begin
    rst_o = 1'b1;
    repeat (4) @(posedge clk_o);
    #1 rst_o = 1'b0;
  end

endmodule

`default_nettype wire

//--- verif/tb_top.sv
`timescale 1ns/1ps
`default_nettype none

module tb_top
  import core_pkg::*;
();

  localparam int          MAX_INSTS       = 160;
  localparam int          CYCLES_PER_INST = 14;  // Latency, stalls and back-pressure.
  localparam int          CYCLE_LIMIT     = 100 + MAX_INSTS * CYCLES_PER_INST;
  localparam logic [31:0] SEED            = 32'h3c26_58b1;

  typedef struct packed {
    reg_idx_t rd;
    word_t    data;
    word_t    pc;
    logic     taken;
    word_t    target;
    logic     chk_rd;
    logic     chk_target;
  } exp_t;

  logic     clk, rst;
  logic     issue_valid_i, issue_ready_o, wb_valid_o, wb_ready_i, wb_taken_o, illegal_o;
  inst_t    inst_i;
  word_t    pc_i, wb_data_o, wb_pc_o, wb_target_o;
  reg_idx_t wb_rd_o;

  word_t       model_regs [NUM_REGS];
  exp_t        exp_q [$];
  logic [31:0] rng_state, bp_state;
  word_t       next_pc;
  logic        bp_en;
  int          cycle_cnt, illegal_seen, illegal_exp, hold_cnt;

  tb_clk_gen i_clk_gen (.clk_o(clk), .rst_o(rst));

  decode_exec_top i_dut (
    .clk, .rst, .issue_valid_i, .inst_i, .pc_i, .issue_ready_o,
    .wb_valid_o, .wb_ready_i, .wb_rd_o, .wb_data_o, .wb_pc_o, .wb_taken_o, .wb_target_o,
    .illegal_o
  );

  task automatic fail_run(input string why);
    $display("%s", why);
    $display("Checks failed");
    $fatal(1, "stopping at first error");
  endtask

  task automatic compare_word(input string name, input word_t got, input word_t exp);
    if (got !== exp) begin
      fail_run($sformatf("MISMATCH time=%0t %s got=%h exp=%h", $time, name, got, exp));
    end
  endtask

  task automatic compare_reg(input string name, input reg_idx_t got, input reg_idx_t exp);
    if (got !== exp) begin
      fail_run($sformatf("MISMATCH time=%0t %s got=%0d exp=%0d", $time, name, got, exp));
    end
  endtask

  task automatic compare_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      fail_run($sformatf("MISMATCH time=%0t %s got=%b exp=%b", $time, name, got, exp));
    end
  endtask

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function automatic logic [31:0] rand32();
    rng_state = xorshift32(rng_state);
    return rng_state;
  endfunction

  // Instruction encoders. Register fields keep their top bit clear.
  function automatic inst_t enc_i(input opcode_t op, input logic [2:0] f3, input reg_idx_t rd,
                                  input reg_idx_t rs1, input logic [11:0] imm);
    return {imm, 1'b0, rs1, f3, 1'b0, rd, op};
  endfunction

  function automatic inst_t enc_r(input logic alt, input reg_idx_t rs2, input reg_idx_t rs1,
                                  input logic [2:0] f3, input reg_idx_t rd);
    return {1'b0, alt, 5'b0, 1'b0, rs2, 1'b0, rs1, f3, 1'b0, rd, OP_REG};
  endfunction

  function automatic inst_t enc_u(input opcode_t op, input logic [19:0] imm, input reg_idx_t rd);
    return {imm, 1'b0, rd, op};
  endfunction

  function automatic inst_t enc_j(input logic [20:0] off, input reg_idx_t rd);
    return {off[20], off[10:1], off[11], off[19:12], 1'b0, rd, OP_JAL};
  endfunction

  function automatic inst_t enc_b(input logic [12:0] off, input reg_idx_t rs2,
                                  input reg_idx_t rs1, input logic [2:0] f3);
    return {off[12], off[10:5], 1'b0, rs2, 1'b0, rs1, f3, off[4:1], off[11], OP_BRANCH};
  endfunction

  // Offsets read back out of the fields that the encoders fill.
  function automatic word_t jal_offset(input inst_t inst);
    logic [20:0] off;
    off        = '0;
    off[20]    = inst[31];
    off[10:1]  = inst[30:21];
    off[11]    = inst[20];
    off[19:12] = inst[19:12];
    return {{11{off[20]}}, off};
  endfunction

  function automatic word_t branch_offset(input inst_t inst);
    logic [12:0] off;
    off       = '0;
    off[12]   = inst[31];
    off[10:5] = inst[30:25];
    off[4:1]  = inst[11:8];
    off[11]   = inst[7];
    return {{19{off[12]}}, off};
  endfunction

  // Random register or immediate ALU op.
  function automatic inst_t rand_alu(input reg_idx_t rd, input reg_idx_t rs1, input reg_idx_t rs2);
    logic [31:0] r;
    logic [2:0]  f3;
    logic        alt;
    logic [11:0] imm;
    r   = rand32();
    f3  = r[2:0];
    alt = r[4] && (f3 == 3'd0 || f3 == 3'd5);
    if (r[3]) begin
      return enc_r(alt, rs2, rs1, f3, rd);
    end
    imm = (f3 == 3'd1 || f3 == 3'd5) ? {1'b0, alt && f3 == 3'd5, 5'b0, r[9:5]} : r[21:10];
    return enc_i(OP_IMM, f3, rd, rs1, imm);
  endfunction

  function automatic word_t alu_ref(input logic [2:0] f3, input logic alt,
                                    input word_t a, input word_t b);
    word_t sra;
    sra = $signed(a) >>> b[4:0];
    case (f3)
      3'd0:    return alt ? a - b : a + b;
      3'd1:    return a << b[4:0];
      3'd2:    return {31'b0, $signed(a) < $signed(b)};
      3'd3:    return {31'b0, a < b};
      3'd4:    return a ^ b;
      3'd5:    return alt ? sra : a >> b[4:0];
      3'd6:    return a | b;
      default: return a & b;
    endcase
  endfunction

  function automatic logic branch_ref(input logic [2:0] f3, input word_t a, input word_t b);
    case (f3)
      3'd0:    return a == b;
      3'd1:    return a != b;
      3'd4:    return $signed(a) < $signed(b);
      3'd5:    return $signed(a) >= $signed(b);
      3'd6:    return a < b;
      3'd7:    return a >= b;
      default: return 1'b0;
    endcase
  endfunction

  // Program-order reference model.
  task automatic predict(input inst_t inst, input word_t pc);
    reg_idx_t rd, rs1, rs2;
    word_t    a, b, imm_i;
    logic [2:0] f3;
    exp_t     e;
    rd    = inst[10:7];
    rs1   = inst[18:15];
    rs2   = inst[23:20];
    f3    = inst[14:12];
    a     = model_regs[rs1];
    b     = model_regs[rs2];
    imm_i = {{20{inst[31]}}, inst[31:20]};
    e     = '0;
    e.pc  = pc;
    e.rd  = rd;
    e.chk_rd = 1'b1;
    case (inst[6:0])
      OP_LUI:   e.data = {inst[31:12], 12'b0};
      OP_AUIPC: e.data = pc + {inst[31:12], 12'b0};
      OP_JAL: begin
        e.data  = pc + 32'd4;
        e.taken = 1'b1;
        e.target = pc + jal_offset(inst);
        e.chk_target = 1'b1;
      end
      OP_JALR: begin
        e.data  = pc + 32'd4;
        e.taken = 1'b1;
        e.target = (a + imm_i) & ~32'd1;
        e.chk_target = 1'b1;
      end
      OP_BRANCH: begin
        e.chk_rd = 1'b0;
        e.taken  = branch_ref(f3, a, b);
        e.target = pc + branch_offset(inst);
        e.chk_target = 1'b1;
      end
      OP_IMM:   e.data = alu_ref(f3, f3 == 3'd5 && inst[30], a, imm_i);
      OP_REG:   e.data = alu_ref(f3, inst[30], a, b);
      default: begin
        illegal_exp++;
        return;
      end
    endcase
    if (e.chk_rd && rd != '0) begin
      model_regs[rd] = e.data;
    end
    exp_q.push_back(e);
  endtask

  // Called a step after a rising edge; returns a step after the accepting edge.
  task automatic issue_inst(input inst_t inst);
    predict(inst, next_pc);
    issue_valid_i = 1'b1;
    inst_i        = inst;
    pc_i          = next_pc;
    do @(negedge clk); while (!issue_ready_o);
    @(posedge clk);
    #1;
    issue_valid_i = 1'b0;
    next_pc       = next_pc + 32'd4;
  endtask

  task automatic drain();
    while (exp_q.size() != 0) @(posedge clk);
    repeat (3) @(posedge clk);
    #1;
  endtask

  task automatic check_retire();
    exp_t e;
    if (exp_q.size() == 0) begin
      fail_run("A result retired with no instruction outstanding");
    end
    e = exp_q.pop_front();
    compare_word("wb_pc_o", wb_pc_o, e.pc);
    if (e.chk_rd) compare_reg("wb_rd_o", wb_rd_o, e.rd);
    compare_word("wb_data_o", wb_data_o, e.data);
    compare_bit("wb_taken_o", wb_taken_o, e.taken);
    if (e.chk_target) compare_word("wb_target_o", wb_target_o, e.target);
  endtask

  // Results are sampled mid-cycle and retire on the next rising edge.
  always @(negedge clk) begin
    if (!rst) begin
      if (illegal_o) illegal_seen++;
      if (wb_valid_o && wb_ready_i) check_retire();
    end
  end

  always @(posedge clk) begin
    cycle_cnt++;
    if (cycle_cnt > CYCLE_LIMIT) begin
      fail_run("Timeout: the tests did not finish within the cycle limit");
    end
  end

  // Consumer stalls in random stretches.
  always @(posedge clk) begin
    #1;
    if (!bp_en) begin
      wb_ready_i = 1'b1;
    end else if (hold_cnt == 0) begin
      bp_state   = xorshift32(bp_state);
      wb_ready_i = bp_state[0];
      hold_cnt   = int'(bp_state[3:1]) + 1;
    end else begin
      hold_cnt--;
    end
  end

  task automatic test_reset();
    @(negedge clk);
    compare_bit("issue_ready_o", issue_ready_o, 1'b1);
    compare_bit("wb_valid_o", wb_valid_o, 1'b0);
    compare_bit("illegal_o", illegal_o, 1'b0);
    @(posedge clk);
    #1;
  endtask

  task automatic test_independent();
    logic [31:0] r;
    reg_idx_t    rd;
    int          n;
    r = rand32();
    issue_inst(enc_u(OP_LUI, r[31:12], 4'd1));
    r = rand32();
    issue_inst(enc_u(OP_LUI, r[31:12], 4'd2));
    issue_inst(enc_u(OP_AUIPC, 20'h00abc, 4'd3));
    issue_inst(enc_i(OP_IMM, 3'd0, 4'd4, 4'd0, 12'hffb));
    drain();
    n = 0;
    for (int f3 = 0; f3 < 8; f3++) begin
      for (int alt = 0; alt < 2; alt++) begin
        if (alt == 0 || f3 == 0 || f3 == 5) begin
          rd = reg_idx_t'(5 + n % 10);  // Sources x1 and x2 are never written here.
          r  = rand32();
          issue_inst(enc_r(alt[0], 4'd2, 4'd1, f3[2:0], rd));
          if (f3 == 1 || f3 == 5) begin
            issue_inst(enc_i(OP_IMM, f3[2:0], rd, 4'd1, {1'b0, alt[0], 5'b0, r[4:0]}));
          end else if (alt == 0) begin
            issue_inst(enc_i(OP_IMM, f3[2:0], rd, 4'd1, r[11:0]));
          end
          n++;
        end
      end
    end
    drain();
  endtask

  task automatic test_chains();
    logic [31:0] r;
    reg_idx_t    rd, prev;
    repeat (4) issue_inst(enc_i(OP_IMM, 3'd0, 4'd5, 4'd5, 12'd1));
    issue_inst(enc_r(1'b0, 4'd5, 4'd5, 3'd0, 4'd6));
    issue_inst(enc_r(1'b1, 4'd5, 4'd6, 3'd0, 4'd7));
    issue_inst(enc_r(1'b0, 4'd5, 4'd7, 3'd1, 4'd8));
    issue_inst(enc_i(OP_JALR, 3'd0, 4'd9, 4'd8, 12'h011));
    prev = 4'd9;
    repeat (20) begin
      r  = rand32();
      rd = (r[3:0] == '0) ? 4'd1 : r[3:0];
      issue_inst(rand_alu(rd, prev, r[7:4]));
      prev = rd;
    end
    drain();
  endtask

  task automatic test_control();
    logic [2:0]  f3s [6];
    logic [31:0] r;
    f3s = '{3'd0, 3'd1, 3'd4, 3'd5, 3'd6, 3'd7};
    issue_inst(enc_i(OP_IMM, 3'd0, 4'd1, 4'd0, 12'd100));
    issue_inst(enc_i(OP_IMM, 3'd0, 4'd2, 4'd0, 12'hffd));
    issue_inst(enc_i(OP_IMM, 3'd0, 4'd3, 4'd0, 12'd100));
    issue_inst(enc_j(21'h000040, 4'd10));
    issue_inst(enc_j(21'h1ffff0, 4'd11));
    issue_inst(enc_i(OP_JALR, 3'd0, 4'd12, 4'd1, 12'h007));
    issue_inst(enc_i(OP_JALR, 3'd0, 4'd13, 4'd12, 12'h000));  // Link value forwarded.
    for (int i = 0; i < 6; i++) begin
      r = rand32();
      issue_inst(enc_b({r[12:1], 1'b0}, 4'd2, 4'd1, f3s[i]));
      issue_inst(enc_b({r[24:13], 1'b0}, 4'd3, 4'd1, f3s[i]));
      issue_inst(enc_b({r[30:19], 1'b0}, 4'd1, 4'd2, f3s[i]));
    end
    drain();
  endtask

  task automatic test_backpressure();
    logic [31:0] r;
    reg_idx_t    rd;
    bp_en = 1'b1;
    repeat (40) begin
      r  = rand32();
      rd = (r[3:0] == '0) ? 4'd14 : r[3:0];
      if (r[31:29] == 3'd0) begin
        issue_inst(enc_j({r[28:9], 1'b0}, rd));
      end else begin
        issue_inst(rand_alu(rd, r[7:4], r[11:8]));
      end
    end
    drain();
    bp_en = 1'b0;
  endtask

  task automatic test_illegal();
    issue_inst({25'h0012345, 7'b0000011});
    issue_inst(enc_i(OP_IMM, 3'd0, 4'd4, 4'd4, 12'd1));
    issue_inst({25'h0000000, 7'b1110011});
    issue_inst(enc_r(1'b0, 4'd4, 4'd4, 3'd0, 4'd5));
    drain();
    compare_word("illegal_o pulse count", word_t'(illegal_seen), word_t'(illegal_exp));
  endtask

  initial begin
    issue_valid_i = 1'b0;
    inst_i        = '0;
    pc_i          = '0;
    wb_ready_i    = 1'b1;
    bp_en         = 1'b0;
    hold_cnt      = 0;
    rng_state     = SEED;
    bp_state      = SEED;
    next_pc       = 32'h0000_0100;
    cycle_cnt     = 0;
    illegal_seen  = 0;
    illegal_exp   = 0;
    for (int i = 0; i < NUM_REGS; i++) begin
      model_regs[i] = '0;
    end
    wait (rst === 1'b1);
    wait (rst === 1'b0);
    @(posedge clk);
    #1;
    test_reset();
    test_independent();
    test_chains();
    test_control();
    test_backpressure();
    test_illegal();
    $display("All checks passed");
    $finish;
  end

endmodule

`default_nettype wire
